//--- uart_top.f
design/uart_pkg.sv
design/baud_gen.sv
design/uart_tx.sv
design/uart_rx.sv
design/rx_holding.sv
design/uart_top.sv
testbench/tb_uart_top.sv

//--- run.sh
#!/bin/sh
# Builds the UART testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_uart_top -f uart_top.f -o tb_uart_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_uart_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" "$log"; then
    exit 0
fi
exit 1

//--- testbench/tb_uart_top.sv
// ########################################
// Directed tests for the UART core, run
// through loopback and an injected rx line
// ########################################
`timescale 1ns/1ps

module tb_uart_top;

    localparam int clk_period     = 20;
    localparam int prescale_value = 1;
    localparam int bit_clocks     = uart_pkg::samples_per_bit * (prescale_value + 1);
    localparam int frame_limit    = 14 * bit_clocks * 2;    // Longest frame, doubled
    // Bits on the line per test: 60 + 108 + 26 + 20 + 30
    localparam int total_bits     = 244;
    localparam int watchdog_ns    = total_bits * bit_clocks * clk_period * 2 + 20000;

    logic                               clk = 1'b0;
    logic                               resetn;
    logic                               enable;
    logic [uart_pkg::prescale_bits-1:0] prescaler;
    uart_pkg::frame_cfg_t               cfg;
    logic                               loopback;
    uart_pkg::data_t                    tx_data;
    logic                               tx_wr;
    logic                               tx;
    logic                               tx_busy;
    logic                               rx;
    logic                               rd;
    uart_pkg::rx_frame_t                rx_word;
    logic                               rx_valid;
    logic                               overrun;

    integer seed;
    int     errors = 0;
    int     checks = 0;

    uart_top dut (
        .clk       (clk),
        .resetn    (resetn),
        .enable    (enable),
        .prescaler (prescaler),
        .cfg       (cfg),
        .loopback  (loopback),
        .tx_data   (tx_data),
        .tx_wr     (tx_wr),
        .tx        (tx),
        .tx_busy   (tx_busy),
        .rx        (rx),
        .rd        (rd),
        .rx_word   (rx_word),
        .rx_valid  (rx_valid),
        .overrun   (overrun)
    );

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic uart_pkg::data_t random_word();
        logic [31:0] r;
        r = $random(seed);
        return r[uart_pkg::max_data_bits-1:0];
    endfunction

    function automatic uart_pkg::data_t mask_word(input uart_pkg::data_t word, input int size);
        uart_pkg::data_t m;
        m = word;
        for (int i = size; i < uart_pkg::max_data_bits; i++) begin
            m[i] = 1'b0;
        end
        return m;
    endfunction

    function automatic logic expected_parity(input uart_pkg::data_t word, input int size,
                                             input uart_pkg::parity_e mode);
        logic x;
        x = 1'b0;
        for (int i = 0; i < size; i++) begin
            x = x ^ word[i];
        end
        case (mode)
            uart_pkg::parity_odd:    return ~x;    // Total ones made odd
            uart_pkg::parity_even:   return x;
            uart_pkg::parity_stick1: return 1'b1;
            default:                 return 1'b0;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("[ERROR] %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic set_format(input int size, input uart_pkg::parity_e mode,
                              input logic two_stop);
        @(posedge clk);
        cfg.data_size <= 4'(size);
        cfg.parity    <= mode;
        cfg.two_stop  <= two_stop;
    endtask

    task automatic write_word(input uart_pkg::data_t word);
        @(posedge clk);
        tx_data <= word;
        tx_wr   <= 1'b1;
        @(posedge clk);
        tx_wr   <= 1'b0;
    endtask

    task automatic read_word;
        @(posedge clk);
        rd <= 1'b1;
        @(posedge clk);
        rd <= 1'b0;
        @(negedge clk);
        compare("rx_valid", 0, rx_valid);
        compare("overrun", 0, overrun);
    endtask

    task automatic wait_rx_valid(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!rx_valid && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (rx_valid) else begin
            errors++;
            $display("No received word arrived within %0d cycles at %0t", limit, $time);
        end
    endtask

    task automatic wait_tx_idle(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (tx_busy && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (!tx_busy) else begin
            errors++;
            $display("Transmitter stayed busy for more than %0d cycles at %0t", limit, $time);
        end
    endtask

    // Holds one bit value on rx for a full bit period
    task automatic hold_line(input logic value);
        rx <= value;
        repeat (bit_clocks) @(posedge clk);
    endtask

    task automatic inject_frame(input uart_pkg::data_t word, input int size,
                                input logic parity_value, input logic stop_value);
        @(posedge clk);
        hold_line(1'b0);
        for (int i = 0; i < size; i++) begin
            hold_line(word[i]);
        end
        hold_line(parity_value);
        hold_line(stop_value);
        hold_line(1'b1);    // Idle gap
        hold_line(1'b1);
    endtask

    // One loopback frame, checked on the line and in the holding register
    task automatic loop_frame(input uart_pkg::data_t word, input int size,
                              input uart_pkg::parity_e mode);
        uart_pkg::data_t expected;
        expected = mask_word(word, size);
        write_word(word);
        @(negedge clk);
        compare("tx_busy", 1, tx_busy);
        compare("tx start bit", 0, tx);
        if (mode != uart_pkg::parity_none) begin
            repeat (bit_clocks * (1 + size) + 7) @(posedge clk);    // Middle of parity bit
            @(negedge clk);
            compare("tx parity bit", expected_parity(expected, size, mode), tx);
        end
        wait_rx_valid(frame_limit);
        compare("rx_word.data", expected, rx_word.data);
        compare("rx_word.parity_error", 0, rx_word.parity_error);
        compare("rx_word.frame_error", 0, rx_word.frame_error);
        read_word();
        wait_tx_idle(frame_limit);
    endtask

    task automatic check_reset_state;
        @(negedge clk);
        compare("tx", 1, tx);
        compare("tx_busy", 0, tx_busy);
        compare("rx_valid", 0, rx_valid);
        compare("overrun", 0, overrun);
        compare("rx_word", 0, rx_word);
    endtask

    task automatic loopback_words;
        set_format(8, uart_pkg::parity_none, 1'b0);
        repeat (6) begin
            loop_frame(random_word(), 8, uart_pkg::parity_none);
        end
    endtask

    task automatic parity_modes;
        uart_pkg::parity_e modes [5] = '{uart_pkg::parity_none, uart_pkg::parity_odd,
                                         uart_pkg::parity_even, uart_pkg::parity_stick0,
                                         uart_pkg::parity_stick1};
        int size;
        for (int s = 0; s < 2; s++) begin
            size = (s == 0) ? 5 : 9;
            for (int m = 0; m < 5; m++) begin
                set_format(size, modes[m], 1'b1);
                loop_frame(random_word(), size, modes[m]);
            end
        end
    endtask

    task automatic injected_errors;
        uart_pkg::data_t word;
        logic            par;
        set_format(8, uart_pkg::parity_even, 1'b0);
        @(posedge clk);
        loopback <= 1'b0;
        word = mask_word(random_word(), 8);
        par  = expected_parity(word, 8, uart_pkg::parity_even);
        inject_frame(word, 8, ~par, 1'b1);    // Wrong parity bit
        wait_rx_valid(frame_limit);
        compare("rx_word.data", word, rx_word.data);
        compare("rx_word.parity_error", 1, rx_word.parity_error);
        compare("rx_word.frame_error", 0, rx_word.frame_error);
        read_word();
        word = mask_word(random_word(), 8);
        par  = expected_parity(word, 8, uart_pkg::parity_even);
        inject_frame(word, 8, par, 1'b0);     // Stop bit low
        wait_rx_valid(frame_limit);
        compare("rx_word.data", word, rx_word.data);
        compare("rx_word.parity_error", 0, rx_word.parity_error);
        compare("rx_word.frame_error", 1, rx_word.frame_error);
        read_word();
        @(posedge clk);
        loopback <= 1'b1;
    endtask

    task automatic overrun_case;
        uart_pkg::data_t first;
        first = random_word();
        set_format(8, uart_pkg::parity_none, 1'b0);
        write_word(first);
        wait_tx_idle(frame_limit);
        write_word(~first);
        wait_tx_idle(frame_limit);    // Second frame is complete before the line idles
        compare("rx_valid", 1, rx_valid);
        compare("overrun", 1, overrun);
        compare("rx_word.data", mask_word(first, 8), rx_word.data);
        read_word();
    endtask

    task automatic busy_write_ignored;
        uart_pkg::data_t first;
        first = random_word();
        set_format(8, uart_pkg::parity_none, 1'b0);
        write_word(first);
        repeat (bit_clocks) @(posedge clk);
        @(negedge clk);
        compare("tx_busy", 1, tx_busy);
        write_word(~first);
        wait_rx_valid(frame_limit);
        compare("rx_word.data", mask_word(first, 8), rx_word.data);
        read_word();
        wait_tx_idle(frame_limit);
        repeat (bit_clocks * 10) @(posedge clk);    // A second frame would have landed
        @(negedge clk);
        compare("rx_valid", 0, rx_valid);
        compare("tx_busy", 0, tx_busy);
    endtask

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired before the tests finished");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        seed      = 32'h8b13_aa02;
        resetn    = 1'b0;
        enable    = 1'b1;
        prescaler = 16'(prescale_value);
        cfg       = '0;
        loopback  = 1'b1;
        tx_data   = '0;
        tx_wr     = 1'b0;
        rd        = 1'b0;
        rx        = 1'b1;
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        check_reset_state();
        loopback_words();
        parity_modes();
        injected_errors();
        overrun_case();
        busy_write_ignored();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- design/uart_top.sv
// ########################################
// UART core top, baud generator, TX, RX,
// holding register and loopback
// ########################################
`timescale 1ns/1ps

module uart_top (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               enable,
    input  logic [uart_pkg::prescale_bits-1:0] prescaler,
    input  uart_pkg::frame_cfg_t               cfg,
    input  logic                               loopback,
    input  uart_pkg::data_t                    tx_data,
    input  logic                               tx_wr,
    output logic                               tx,
    output logic                               tx_busy,
    input  logic                               rx,
    input  logic                               rd,
    output uart_pkg::rx_frame_t                rx_word,
    output logic                               rx_valid,
    output logic                               overrun
);

    logic                tick;
    logic                rx_line;
    logic                rx_done;
    uart_pkg::rx_frame_t rx_frame;

    assign rx_line = loopback ? tx : rx;    // Internal wrap of the serial line

    baud_gen u_baud_gen (
        .clk       (clk),
        .resetn    (resetn),
        .enable    (enable),
        .prescaler (prescaler),
        .tick      (tick)
    );

    uart_tx u_uart_tx (
        .clk     (clk),
        .resetn  (resetn),
        .tick    (tick),
        .cfg     (cfg),
        .tx_data (tx_data),
        .tx_wr   (tx_wr),
        .tx      (tx),
        .tx_busy (tx_busy)
    );

    uart_rx u_uart_rx (
        .clk     (clk),
        .resetn  (resetn),
        .tick    (tick),
        .cfg     (cfg),
        .rx      (rx_line),
        .rx_done (rx_done),
        .frame   (rx_frame)
    );

    rx_holding u_rx_holding (
        .clk      (clk),
        .resetn   (resetn),
        .rx_done  (rx_done),
        .frame    (rx_frame),
        .rd       (rd),
        .rx_word  (rx_word),
        .rx_valid (rx_valid),
        .overrun  (overrun)
    );

endmodule

//--- design/rx_holding.sv
// ########################################
// One-entry receive buffer with overrun
// ########################################
`timescale 1ns/1ps

module rx_holding (
    input  logic                clk,
    input  logic                resetn,
    input  logic                rx_done,
    input  uart_pkg::rx_frame_t frame,
    input  logic                rd,
    output uart_pkg::rx_frame_t rx_word,
    output logic                rx_valid,
    output logic                overrun
);

    logic accept;

    assign accept = rx_done && (!rx_valid || rd);    // Read frees the slot this cycle

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rx_valid <= 1'b0;
            overrun  <= 1'b0;
        end else if (accept) begin
            rx_valid <= 1'b1;
            overrun  <= 1'b0;
        end else if (rx_done) begin
            overrun  <= 1'b1;    // New frame lost
        end else if (rd) begin
            rx_valid <= 1'b0;
            overrun  <= 1'b0;
        end
    end

    // Visible word is zero out of reset
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rx_word <= '0;
        end else if (accept) begin
            rx_word <= frame;
        end
    end

    a_overrun_needs_valid: assert property (
        @(posedge clk) disable iff (!resetn) overrun |-> rx_valid
    ) else $error("rx_holding: overrun without a held word");

endmodule

//--- design/uart_rx.sv
// ########################################
// Synchronizer and frame receiver, pulses
// rx_done with the checked word
// ########################################
`timescale 1ns/1ps

module uart_rx (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 tick,
    input  uart_pkg::frame_cfg_t cfg,
    input  logic                 rx,
    output logic                 rx_done,
    output uart_pkg::rx_frame_t  frame
);

    logic                                rx_meta;
    logic                                rx_sync;
    uart_pkg::uart_state_e               state;
    logic [uart_pkg::tick_cnt_bits-1:0] tick_cnt;
    logic [uart_pkg::bit_cnt_bits-1:0]  bit_cnt;
    uart_pkg::data_t                     shift_reg;
    uart_pkg::data_t                     rx_data;
    logic                                par_err;
    logic                                stop_err;
    logic                                bit_end;
    logic                                start_mid;
    logic                                last_stop;

    // Two-flop synchronizer, idles high
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign bit_end   = tick && (tick_cnt == uart_pkg::last_tick);
    assign start_mid = tick && (tick_cnt == uart_pkg::mid_tick) && (state == uart_pkg::st_start);
    assign last_stop = (state == uart_pkg::st_stop1) ||
                       ((state == uart_pkg::st_stop0) && !cfg.two_stop);
    assign rx_data   = shift_reg >> (4'(uart_pkg::max_data_bits) - cfg.data_size);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            tick_cnt <= '0;
        end else if (state == uart_pkg::st_idle) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= (bit_end || start_mid) ? '0 : tick_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state   <= uart_pkg::st_idle;
            bit_cnt <= '0;
        end else begin
            case (state)
                uart_pkg::st_idle: begin
                    if (tick && !rx_sync) begin
                        state <= uart_pkg::st_start;
                    end
                end
                uart_pkg::st_start: begin
                    if (start_mid) begin
                        bit_cnt <= '0;
                        state   <= rx_sync ? uart_pkg::st_idle : uart_pkg::st_data;    // Glitch
                    end
                end
                uart_pkg::st_data: begin
                    if (bit_end) begin
                        if (bit_cnt == cfg.data_size - 4'd1) begin
                            state <= uart_pkg::parity_used(cfg.parity) ?
                                     uart_pkg::st_parity : uart_pkg::st_stop0;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                uart_pkg::st_parity: begin
                    if (bit_end) begin
                        state <= uart_pkg::st_stop0;
                    end
                end
                uart_pkg::st_stop0: begin
                    if (bit_end) begin
                        state <= cfg.two_stop ? uart_pkg::st_stop1 : uart_pkg::st_idle;
                    end
                end
                default: begin
                    if (bit_end || (state != uart_pkg::st_stop1)) begin
                        state <= uart_pkg::st_idle;
                    end
                end
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if ((state == uart_pkg::st_data) && bit_end) begin
            shift_reg <= {rx_sync, shift_reg[uart_pkg::max_data_bits-1:1]};
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            par_err  <= 1'b0;
            stop_err <= 1'b0;
        end else if (state == uart_pkg::st_idle) begin
            par_err  <= 1'b0;
            stop_err <= 1'b0;
        end else if (bit_end) begin
            if ((state == uart_pkg::st_parity) &&
                (rx_sync != uart_pkg::parity_bit(rx_data, cfg.parity))) begin
                par_err <= 1'b1;
            end
            if (((state == uart_pkg::st_stop0) || (state == uart_pkg::st_stop1)) && !rx_sync) begin
                stop_err <= 1'b1;
            end
        end
    end

    assign rx_done            = bit_end && last_stop;
    assign frame.data         = rx_data;
    assign frame.parity_error = par_err;
    assign frame.frame_error  = stop_err | (rx_done & ~rx_sync);    // Last stop bit sampled now

    a_done_single: assert property (
        @(posedge clk) disable iff (!resetn) rx_done |=> !rx_done
    ) else $error("uart_rx: rx_done longer than one cycle");

endmodule

//--- design/uart_tx.sv
// ########################################
// Frame serializer, started by a write
// strobe while the line is idle
// ########################################
`timescale 1ns/1ps

module uart_tx (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 tick,
    input  uart_pkg::frame_cfg_t cfg,
    input  uart_pkg::data_t      tx_data,
    input  logic                 tx_wr,
    output logic                 tx,
    output logic                 tx_busy
);

    uart_pkg::uart_state_e               state;
    logic [uart_pkg::tick_cnt_bits-1:0] tick_cnt;
    logic [uart_pkg::bit_cnt_bits-1:0]  bit_cnt;
    uart_pkg::data_t                     shift_reg;
    logic                                par_bit;
    uart_pkg::data_t                     masked;
    logic                                bit_end;
    logic                                load;

    assign masked  = tx_data & uart_pkg::width_mask(cfg.data_size);
    assign bit_end = tick && (tick_cnt == uart_pkg::last_tick);
    assign tx_busy = (state != uart_pkg::st_idle);
    assign load    = (state == uart_pkg::st_idle) && tx_wr;    // Writes while busy are dropped

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            tick_cnt <= '0;
        end else if (state == uart_pkg::st_idle) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state   <= uart_pkg::st_idle;
            bit_cnt <= '0;
            tx      <= 1'b1;
        end else begin
            case (state)
                uart_pkg::st_idle: begin
                    if (load) begin
                        state <= uart_pkg::st_start;
                        tx    <= 1'b0;    // Start bit goes out with tx_busy
                    end
                end
                uart_pkg::st_start: begin
                    if (bit_end) begin
                        state   <= uart_pkg::st_data;
                        bit_cnt <= '0;
                        tx      <= shift_reg[0];
                    end
                end
                uart_pkg::st_data: begin
                    if (bit_end) begin
                        if (bit_cnt == cfg.data_size - 4'd1) begin
                            if (uart_pkg::parity_used(cfg.parity)) begin
                                state <= uart_pkg::st_parity;
                                tx    <= par_bit;
                            end else begin
                                state <= uart_pkg::st_stop0;
                                tx    <= 1'b1;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx      <= shift_reg[1];    // Next bit before the shift lands
                        end
                    end
                end
                uart_pkg::st_parity: begin
                    if (bit_end) begin
                        state <= uart_pkg::st_stop0;
                        tx    <= 1'b1;
                    end
                end
                uart_pkg::st_stop0: begin
                    if (bit_end) begin
                        state <= cfg.two_stop ? uart_pkg::st_stop1 : uart_pkg::st_idle;
                    end
                end
                uart_pkg::st_stop1: begin
                    if (bit_end) begin
                        state <= uart_pkg::st_idle;
                    end
                end
                default: begin
                    state <= uart_pkg::st_idle;
                    tx    <= 1'b1;
                end
            endcase
        end
    end

    // Word and parity captured once per frame
    always_ff @(posedge clk) begin
        if (load) begin
            shift_reg <= masked;
            par_bit   <= uart_pkg::parity_bit(masked, cfg.parity);
        end else if ((state == uart_pkg::st_data) && bit_end) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    a_idle_line_high: assert property (
        @(posedge clk) disable iff (!resetn) !tx_busy |-> tx
    ) else $error("uart_tx: line low while idle");

endmodule

//--- design/baud_gen.sv
// ########################################
// Oversampling tick, one per prescaler+1
// clocks while enabled
// ########################################
`timescale 1ns/1ps

module baud_gen (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               enable,
    input  logic [uart_pkg::prescale_bits-1:0] prescaler,
    output logic                               tick
);

    logic [uart_pkg::prescale_bits-1:0] count;
    logic                               wrap;

    assign wrap = (count >= prescaler);    // Also recovers from a lowered prescaler
    assign tick = enable && wrap;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            count <= '0;
        end else if (enable) begin
            count <= wrap ? '0 : count + 1'b1;
        end
    end

    // Counter restarts from zero after every tick
    a_tick_pulse: assert property (
        @(posedge clk) disable iff (!resetn) tick |=> !tick || (prescaler == '0)
    ) else $error("baud_gen: back-to-back ticks with a nonzero prescaler");

endmodule

//--- design/uart_pkg.sv
// ########################################
// Shared sizes, encodings and frame types
// for the UART core and its testbench
// ########################################
package uart_pkg;

    localparam int max_data_bits   = 9;
    localparam int samples_per_bit = 8;
    localparam int prescale_bits   = 16;
    localparam int tick_cnt_bits   = $clog2(samples_per_bit);
    localparam int bit_cnt_bits    = 4;

    localparam logic [tick_cnt_bits-1:0] last_tick = tick_cnt_bits'(samples_per_bit - 1);
    localparam logic [tick_cnt_bits-1:0] mid_tick  = tick_cnt_bits'(samples_per_bit / 2 - 1);

    typedef logic [max_data_bits-1:0] data_t;

    typedef enum logic [2:0] {
        parity_none   = 3'd0,
        parity_odd    = 3'd1,
        parity_even   = 3'd2,
        parity_stick0 = 3'd4,
        parity_stick1 = 3'd5
    } parity_e;

    // Bit position within a frame, common to transmitter and receiver
    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop0,
        st_stop1
    } uart_state_e;

    typedef struct packed {
        logic [3:0] data_size;    // 5 to 9
        parity_e    parity;
        logic       two_stop;
    } frame_cfg_t;

    typedef struct packed {
        data_t data;              // Right aligned
        logic  parity_error;
        logic  frame_error;
    } rx_frame_t;

    // Keeps only the low size bits of a word
    function automatic data_t width_mask(logic [3:0] size);
        return ~({max_data_bits{1'b1}} << size);
    endfunction

    function automatic logic parity_used(parity_e p);
        return p inside {parity_odd, parity_even, parity_stick0, parity_stick1};
    endfunction

    // Expected parity bit for a masked data word
    function automatic logic parity_bit(data_t word, parity_e p);
        case (p)
            parity_odd:    return ~^word;
            parity_even:   return ^word;
            parity_stick1: return 1'b1;
            default:       return 1'b0;
        endcase
    endfunction

endpackage
